// File: common/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// window geometry
`define CONV_TAPS   16
`define CONV_LANES  4      // must divide CONV_TAPS

// operand, product and result width
`define CONV_WORD_W 32

`endif

// File: common/conv_pkg.sv
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

    // operand, product or running sum, wraps modulo 2^CONV_WORD_W
    typedef logic [`CONV_WORD_W-1:0] word_t;

    typedef logic [$clog2(`CONV_TAPS)-1:0] slot_t;   // tap index in the window

    // tap index inside one lane
    typedef logic [$clog2(`CONV_TAPS/`CONV_LANES)-1:0] lane_slot_t;

endpackage

`default_nettype wire

// File: common/tap_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tap_bus_if;
    import conv_pkg::*;

    // filter matrix write ports, 0 carries rs1 and 1 carries rs2
    logic  filt0_en;
    slot_t filt0_slot;
    word_t filt0_data;
    logic  filt1_en;
    slot_t filt1_slot;
    word_t filt1_data;

    // data matrix write ports, same layout
    logic  data0_en;
    slot_t data0_slot;
    word_t data0_data;
    logic  data1_en;
    slot_t data1_slot;
    word_t data1_data;

    logic  clr_filt;
    logic  clr_data;
    logic  run;        // sample the window this cycle

    modport loader (
        output filt0_en, filt0_slot, filt0_data, filt1_en, filt1_slot, filt1_data,
        output data0_en, data0_slot, data0_data, data1_en, data1_slot, data1_data,
        output clr_filt, clr_data, run
    );

    modport lane (
        input filt0_en, filt0_slot, filt0_data, filt1_en, filt1_slot, filt1_data,
        input data0_en, data0_slot, data0_data, data1_en, data1_slot, data1_data,
        input clr_filt, clr_data, run
    );

endinterface

`default_nettype wire

// File: logic/tap_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tap_loader (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            unit_en_i,
    input  conv_pkg::word_t rs1_data_i,
    input  conv_pkg::word_t rs2_data_i,
    input  logic            filt_rs1_en_i,
    input  logic            filt_rs2_en_i,
    input  logic            filt_clr_i,
    input  logic            data_rs1_en_i,
    input  logic            data_rs2_en_i,
    input  logic            data_clr_i,
    input  logic            conv_run_i,
    tap_bus_if.loader       bus
);
    import conv_pkg::*;

    slot_t filt_ptr_q;
    slot_t data_ptr_q;
    logic  filt_clr;
    logic  data_clr;
    logic  filt_wr0;
    logic  filt_wr1;
    logic  data_wr0;
    logic  data_wr1;

    // strobes count only while the decoder selects the unit
    assign filt_clr = unit_en_i & filt_clr_i;
    assign data_clr = unit_en_i & data_clr_i;

    // a clear swallows loads to the same matrix
    assign filt_wr0 = unit_en_i & filt_rs1_en_i & ~filt_clr_i;
    assign filt_wr1 = unit_en_i & filt_rs2_en_i & ~filt_clr_i;
    assign data_wr0 = unit_en_i & data_rs1_en_i & ~data_clr_i;
    assign data_wr1 = unit_en_i & data_rs2_en_i & ~data_clr_i;

    // write pointers advance by the number of words written, wrap 15 -> 0
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            filt_ptr_q <= '0;
            data_ptr_q <= '0;
        end else begin
            if (filt_clr)
                filt_ptr_q <= '0;
            else
                filt_ptr_q <= filt_ptr_q + slot_t'(filt_wr0) + slot_t'(filt_wr1);

            if (data_clr)
                data_ptr_q <= '0;
            else
                data_ptr_q <= data_ptr_q + slot_t'(data_wr0) + slot_t'(data_wr1);
        end
    end

    assign bus.filt0_en   = filt_wr0;
    assign bus.filt0_slot = filt_ptr_q;
    assign bus.filt0_data = rs1_data_i;
    assign bus.filt1_en   = filt_wr1;
    assign bus.filt1_slot = filt_ptr_q + slot_t'(1);   // rs2 lands one slot up
    assign bus.filt1_data = rs2_data_i;

    assign bus.data0_en   = data_wr0;
    assign bus.data0_slot = data_ptr_q;
    assign bus.data0_data = rs1_data_i;
    assign bus.data1_en   = data_wr1;
    assign bus.data1_slot = data_ptr_q + slot_t'(1);
    assign bus.data1_data = rs2_data_i;

    assign bus.clr_filt   = filt_clr;
    assign bus.clr_data   = data_clr;
    assign bus.run        = unit_en_i & conv_run_i;

    // decoder never issues an rs2 load on its own
    a_rs2_with_rs1: assert property (@(posedge clk_i) disable iff (rst_i)
        unit_en_i |-> (!filt_rs2_en_i || filt_rs1_en_i) && (!data_rs2_en_i || data_rs1_en_i))
        else $error("tap_loader: rs2 load strobe without rs1");

endmodule

`default_nettype wire

// File: mac_lane/mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module mac_lane #(
    parameter int LANE_ID = 0
) (
    input  logic            clk_i,
    input  logic            rst_i,
    tap_bus_if.lane         bus,
    output conv_pkg::word_t lane_sum_o,
    output logic            lane_valid_o
);
    import conv_pkg::*;

    localparam int LANE_TAPS = `CONV_TAPS / `CONV_LANES;
    localparam int LOCAL_W   = $bits(lane_slot_t);

    // write ports regrouped per matrix, index 0 is filter and 1 is data
    logic  wr_en   [2][2];
    slot_t wr_slot [2][2];
    word_t wr_data [2][2];
    logic  clr     [2];

    word_t prod_q [LANE_TAPS];
    logic  prod_vld_q;
    word_t prod_sum;
    word_t lane_sum_q;
    logic  lane_vld_q;

    assign wr_en[0][0]   = bus.filt0_en;
    assign wr_slot[0][0] = bus.filt0_slot;
    assign wr_data[0][0] = bus.filt0_data;
    assign wr_en[0][1]   = bus.filt1_en;
    assign wr_slot[0][1] = bus.filt1_slot;
    assign wr_data[0][1] = bus.filt1_data;
    assign wr_en[1][0]   = bus.data0_en;
    assign wr_slot[1][0] = bus.data0_slot;
    assign wr_data[1][0] = bus.data0_data;
    assign wr_en[1][1]   = bus.data1_en;
    assign wr_slot[1][1] = bus.data1_slot;
    assign wr_data[1][1] = bus.data1_data;
    assign clr[0]        = bus.clr_filt;
    assign clr[1]        = bus.clr_data;

    for (genvar m = 0; m < 2; m++) begin : g_mat
        word_t                tap_q [LANE_TAPS];
        logic [LANE_TAPS-1:0] vld_q;
        logic [1:0]           hit;
        lane_slot_t           loc [2];

        for (genvar p = 0; p < 2; p++) begin : g_port
            // upper slot bits select the lane
            assign hit[p] = wr_en[m][p] && ((wr_slot[m][p] >> LOCAL_W) == slot_t'(LANE_ID));
            assign loc[p] = lane_slot_t'(wr_slot[m][p]);
        end

        always_ff @(posedge clk_i) begin
            if (rst_i || clr[m]) begin
                vld_q <= '0;
                for (int i = 0; i < LANE_TAPS; i++)
                    tap_q[i] <= '0;
            end else begin
                if (hit[0]) begin
                    tap_q[loc[0]] <= wr_data[m][0];
                    vld_q[loc[0]] <= 1'b1;
                end
                if (hit[1]) begin
                    tap_q[loc[1]] <= wr_data[m][1];
                    vld_q[loc[1]] <= 1'b1;
                end
            end
        end

        // loader pointers keep rs1 and rs2 on distinct slots
        a_no_slot_clash: assert property (@(posedge clk_i) disable iff (rst_i)
            (&hit) |-> (loc[0] != loc[1]))
            else $error("mac_lane %0d: two writes to local slot %0d", LANE_ID, loc[0]);
    end

    // stage 1, products from the window as it stood before this edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < LANE_TAPS; i++)
                prod_q[i] <= '0;
        end else if (bus.run) begin
            for (int i = 0; i < LANE_TAPS; i++) begin
                if (g_mat[0].vld_q[i] && g_mat[1].vld_q[i])
                    prod_q[i] <= word_t'(g_mat[0].tap_q[i] * g_mat[1].tap_q[i]);
                else
                    prod_q[i] <= '0;   // half-loaded tap adds nothing
            end
        end
    end

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < LANE_TAPS; i++)
            prod_sum = prod_sum + prod_q[i];
    end

    // stage 2, lane partial sum
    always_ff @(posedge clk_i) begin
        if (rst_i)
            lane_sum_q <= '0;
        else if (prod_vld_q)
            lane_sum_q <= prod_sum;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prod_vld_q <= 1'b0;
            lane_vld_q <= 1'b0;
        end else begin
            prod_vld_q <= bus.run;
            lane_vld_q <= prod_vld_q;
        end
    end

    assign lane_sum_o   = lane_sum_q;
    assign lane_valid_o = lane_vld_q;

endmodule

`default_nettype wire

// File: logic/sum_reducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module sum_reducer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  conv_pkg::word_t        lane_sum_i [`CONV_LANES],
    input  logic [`CONV_LANES-1:0] lane_valid_i,
    output conv_pkg::word_t        result_o,
    output logic                   result_valid_o
);
    import conv_pkg::*;

    word_t total;
    logic  all_valid;
    word_t result_q;
    logic  result_vld_q;

    assign all_valid = &lane_valid_i;

    // carries out of bit 31 are dropped
    always_comb begin
        total = '0;
        for (int l = 0; l < `CONV_LANES; l++)
            total = total + lane_sum_i[l];
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q     <= '0;
            result_vld_q <= 1'b0;
        end else begin
            result_vld_q <= all_valid;
            result_q     <= all_valid ? total : '0;   // idle output reads zero
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_vld_q;

    // every lane sees the same run strobe, so they finish together
    a_lanes_in_step: assert property (@(posedge clk_i) disable iff (rst_i)
        (|lane_valid_i) |-> all_valid)
        else $error("sum_reducer: lane valids disagree, got %b", lane_valid_i);

endmodule

`default_nettype wire

// File: logic/conv_accel.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_accel (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            unit_en_i,     // decoder selects this unit
    input  conv_pkg::word_t rs1_data_i,
    input  conv_pkg::word_t rs2_data_i,
    input  logic            filt_rs1_en_i,
    input  logic            filt_rs2_en_i,
    input  logic            filt_clr_i,
    input  logic            data_rs1_en_i,
    input  logic            data_rs2_en_i,
    input  logic            data_clr_i,
    input  logic            conv_run_i,
    output conv_pkg::word_t result_o,
    output logic            result_valid_o
);
    import conv_pkg::*;

    word_t                 lane_sum   [`CONV_LANES];
    logic [`CONV_LANES-1:0] lane_valid;

    tap_bus_if tap_bus ();

    tap_loader i_tap_loader (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .unit_en_i     (unit_en_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .filt_rs1_en_i (filt_rs1_en_i),
        .filt_rs2_en_i (filt_rs2_en_i),
        .filt_clr_i    (filt_clr_i),
        .data_rs1_en_i (data_rs1_en_i),
        .data_rs2_en_i (data_rs2_en_i),
        .data_clr_i    (data_clr_i),
        .conv_run_i    (conv_run_i),
        .bus           (tap_bus.loader)
    );

    // each lane owns CONV_TAPS/CONV_LANES consecutive taps
    for (genvar g = 0; g < `CONV_LANES; g++) begin : g_lane
        mac_lane #(
            .LANE_ID (g)
        ) i_mac_lane (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .bus          (tap_bus.lane),
            .lane_sum_o   (lane_sum[g]),
            .lane_valid_o (lane_valid[g])
        );
    end

    sum_reducer i_sum_reducer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lane_sum_i     (lane_sum),
        .lane_valid_i   (lane_valid),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

endmodule

`default_nettype wire

// File: bench/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

`include "conv_defines.svh"

// reference copy of the tap window, matrix 0 is filter and 1 is data
word_t                 win_tap [2][`CONV_TAPS];
logic [`CONV_TAPS-1:0] win_vld [2];
int                    win_ptr [2];

function automatic void reset_window();
    for (int m = 0; m < 2; m++) begin
        for (int i = 0; i < `CONV_TAPS; i++)
            win_tap[m][i] = '0;
        win_vld[m] = '0;
        win_ptr[m] = 0;
    end
endfunction

// one accepted cycle of strobes for one matrix
function automatic void update_matrix(int m, logic clr, logic rs1_en, logic rs2_en,
                                      word_t rs1, word_t rs2);
    int slot;
    if (clr) begin
        // loads in the same cycle are lost
        for (int i = 0; i < `CONV_TAPS; i++)
            win_tap[m][i] = '0;
        win_vld[m] = '0;
        win_ptr[m] = 0;
    end else begin
        if (rs1_en) begin
            win_tap[m][win_ptr[m]] = rs1;
            win_vld[m][win_ptr[m]] = 1'b1;
        end
        if (rs2_en) begin
            slot = (win_ptr[m] + 1) % `CONV_TAPS;   // rs2 goes one slot above rs1
            win_tap[m][slot] = rs2;
            win_vld[m][slot] = 1'b1;
        end
        win_ptr[m] = (win_ptr[m] + int'(rs1_en) + int'(rs2_en)) % `CONV_TAPS;
    end
endfunction

// sum over taps where both words are loaded, wraps at 32 bits
function automatic word_t dot_product();
    word_t acc;
    word_t prod;
    acc = '0;
    for (int i = 0; i < `CONV_TAPS; i++) begin
        if (win_vld[0][i] && win_vld[1][i]) begin
            prod = win_tap[0][i] * win_tap[1][i];
            acc  = acc + prod;
        end
    end
    return acc;
endfunction

`endif

// File: bench/conv_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_accel_tb;
    import conv_pkg::*;

    `include "conv_model.svh"

    localparam int NUM_CYCLES  = 2000;
    localparam int DRAIN_LIMIT = 10;
    localparam int LATENCY     = 3;
    localparam int BURST_START = 1200;   // every cycle carries a run here
    localparam int BURST_LEN   = 40;

    logic  clk = 1'b0;
    logic  rst;
    logic  unit_en;
    word_t rs1_data;
    word_t rs2_data;
    logic  filt_rs1_en;
    logic  filt_rs2_en;
    logic  filt_clr;
    logic  data_rs1_en;
    logic  data_rs2_en;
    logic  data_clr;
    logic  conv_run;
    word_t result;
    logic  result_valid;

    int    cycle;
    int    waited;
    int    results_seen;
    int    due_q [$];       // cycle in which each result must show up
    word_t exp_q [$];

    conv_accel i_conv_accel (
        .clk_i          (clk),
        .rst_i          (rst),
        .unit_en_i      (unit_en),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .filt_rs1_en_i  (filt_rs1_en),
        .filt_rs2_en_i  (filt_rs2_en),
        .filt_clr_i     (filt_clr),
        .data_rs1_en_i  (data_rs1_en),
        .data_rs2_en_i  (data_rs2_en),
        .data_clr_i     (data_clr),
        .conv_run_i     (conv_run),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    always #20 clk = ~clk;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at cycle %0d", cycle);
    endtask

    task automatic drive_idle();
        unit_en     = 1'b0;
        rs1_data    = '0;
        rs2_data    = '0;
        filt_rs1_en = 1'b0;
        filt_rs2_en = 1'b0;
        filt_clr    = 1'b0;
        data_rs1_en = 1'b0;
        data_rs2_en = 1'b0;
        data_clr    = 1'b0;
        conv_run    = 1'b0;
    endtask

    // outputs are sampled on the falling edge, half a period after they change
    task automatic check_outputs();
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            assert (result_valid === 1'b1)
            else report_failure($sformatf("FAILED result_valid_o: got %h expected %h",
                                          result_valid, 1'b1));
            assert (result === exp_q[0])
            else report_failure($sformatf("FAILED result_o: got %h expected %h",
                                          result, exp_q[0]));
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            results_seen++;
        end else begin
            assert (result_valid === 1'b0)
            else report_failure($sformatf("FAILED result_valid_o: got %h expected %h",
                                          result_valid, 1'b0));
            assert (result === '0)
            else report_failure($sformatf("FAILED result_o: got %h expected %h",
                                          result, 32'h0));
        end
    endtask

    task automatic drive_random_cycle(bit force_run);
        int pick;
        unit_en  = ($urandom % 100) >= 12;
        rs1_data = $urandom;
        rs2_data = $urandom;

        // rs2 only ever comes together with rs1
        pick        = $urandom % 3;
        filt_rs1_en = pick != 0;
        filt_rs2_en = pick == 2;
        pick        = $urandom % 3;
        data_rs1_en = pick != 0;
        data_rs2_en = pick == 2;

        filt_clr = ($urandom % 100) < 3;
        data_clr = ($urandom % 100) < 3;
        conv_run = force_run || (($urandom % 100) < 30);

        // a run sees the window before this cycle's writes and clears
        if (unit_en && conv_run) begin
            due_q.push_back(cycle + LATENCY);
            exp_q.push_back(dot_product());
        end
        if (unit_en) begin
            update_matrix(0, filt_clr, filt_rs1_en, filt_rs2_en, rs1_data, rs2_data);
            update_matrix(1, data_clr, data_rs1_en, data_rs2_en, rs1_data, rs2_data);
        end
    endtask

    initial begin
        void'($urandom(43034));
        rst = 1'b1;
        drive_idle();
        reset_window();
        cycle        = 0;
        results_seen = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            check_outputs();
            drive_random_cycle(n >= BURST_START && n < BURST_START + BURST_LEN);
            cycle++;
            @(negedge clk);
        end

        // let runs in flight come out
        drive_idle();
        waited = 0;
        while (due_q.size() != 0 && waited < DRAIN_LIMIT) begin
            check_outputs();
            cycle++;
            waited++;
            @(negedge clk);
        end

        if (due_q.size() != 0) begin
            report_failure($sformatf("%0d expected results never arrived", due_q.size()));
        end else begin
            // nothing else may come out once the queue is empty
            for (int n = 0; n < LATENCY + 1; n++) begin
                check_outputs();
                cycle++;
                @(negedge clk);
            end
            $display("checked %0d results over %0d cycles", results_seen, cycle);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
+incdir+bench
common/conv_pkg.sv
common/tap_bus_if.sv
logic/tap_loader.sv
mac_lane/mac_lane.sv
logic/sum_reducer.sv
logic/conv_accel.sv
bench/conv_accel_tb.sv
